// File: sim/seq_golden.txt
# R op vs1 use1 vs2 use2 vd use_vd id hz_vs1 hz_vs2 hz_vd (hazard vectors in hex)
# S op vs1 use1 vs2 use2 vd use_vd cycles, D unit id, A err exp_err, I idle
# op 0 VADD 1 VSUB 2 VMUL 3 VMACC 4 VLE 5 VSE, unit 0 ALU 1 MFPU 2 load 3 store
I 1
R 0 1 1 2 1 3 1 0 00 00 00
I 0
# RAW on v3 from ID 0
R 2 3 1 4 1 5 1 1 01 00 00
# RAW on v5, WAR on v1
R 1 6 1 5 1 1 1 2 01 03 00
# RAW on v5, WAR and WAW on v3
R 3 5 1 7 1 3 1 3 02 02 01
# ALU holds two instructions
S 0 8 1 9 1 10 1 10
D 0 0
R 0 8 1 9 1 10 1 0 00 00 00
# Load writes v2, old reader ID 0 is gone
R 4 0 0 0 0 2 1 4 00 00 00
# Nothing issues before the acknowledge
S 5 2 1 0 0 0 0 5
A 1 1
# Store reads v2 from the load
R 5 2 1 0 0 0 0 5 10 00 00
A 0 0
D 2 4
D 0 2
D 1 1
I 0
# Writer of v5 finished, v3 still written by ID 3
R 2 5 1 3 1 6 1 1 00 08 00
R 0 6 1 10 1 9 1 2 03 01 00
D 3 5
D 0 0
D 0 2
D 1 1
D 1 3
I 1

// File: sim.f
+incdir+source
source/seq_pkg.sv
source/vinsn_tracker.sv
source/vreg_scoreboard.sv
source/unit_queue_ctrl.sv
source/issue_ctrl.sv
source/vec_sequencer.sv
sim/tb_vec_sequencer.sv

// File: Bender.yml
package:
  name: vec_sequencer

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/seq_pkg.sv
      - source/vinsn_tracker.sv
      - source/vreg_scoreboard.sv
      - source/unit_queue_ctrl.sv
      - source/issue_ctrl.sv
      - source/vec_sequencer.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/tb_vec_sequencer.sv

// File: sim/tb_vec_sequencer.sv
//////////////////////////////
// Vector sequencer testbench
// Replays the golden event file and
// checks issue, hazards, stalls,
// responses and idle
//////////////////////////////

`include "seq_macros.svh"

module tb_vec_sequencer import seq_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic clk_i, rst_ni, req_valid_i, req_ready_o;
  seq_op_e req_op_i, pe_req_op_o;
  vreg_t req_vs1_i, req_vs2_i, req_vd_i, pe_req_vs1_o, pe_req_vs2_o, pe_req_vd_o;
  logic req_use_vs1_i, req_use_vs2_i, req_use_vd_i;
  logic resp_valid_o, resp_error_o, idle_o, pe_req_valid_o, pe_req_ready_i;
  logic addrgen_ack_i, addrgen_error_i;
  vid_t pe_req_id_o;
  vinsn_vec_t pe_hazard_vs1_o, pe_hazard_vs2_o, pe_hazard_vd_o, vinsn_running_o;
  vinsn_vec_t [`SEQ_NR_VINSN-1:0] hazard_table_o;
  vinsn_vec_t [`SEQ_NR_UNITS-1:0] unit_done_i;
  int errors = 0;
  integer seed = 79718;

  vec_sequencer dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Operand requesters drop ready on random cycles
  initial begin
    forever begin
      @(posedge clk_i);
      pe_req_ready_i <= ($random(seed) % 4) != 0;
    end
  end

  ////////////////////////////////
  // Compare tasks
  ////////////////////////////////

  task automatic check_vid(input vid_t got, input vid_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_vec(input vinsn_vec_t got, input vinsn_vec_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_vreg(input vreg_t got, input vreg_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is v%0d, expected v%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_op(input seq_op_e got, input seq_op_e exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////
  // Event tasks
  ////////////////////////////////

  task automatic drive_request(input seq_op_e op, input vreg_t vs1, input logic u1,
                               input vreg_t vs2, input logic u2, input vreg_t vd,
                               input logic ud);
    @(posedge clk_i);
    req_valid_i   <= 1'b1;
    req_op_i      <= op;
    req_vs1_i     <= vs1;
    req_use_vs1_i <= u1;
    req_vs2_i     <= vs2;
    req_use_vs2_i <= u2;
    req_vd_i      <= vd;
    req_use_vd_i  <= ud;
  endtask

  // Hold the request until taken, then check what reaches the processing elements
  task automatic issue_request(input seq_op_e op, input vreg_t vs1, input logic u1,
                               input vreg_t vs2, input logic u2, input vreg_t vd,
                               input logic ud, input vid_t id, input vinsn_vec_t h1,
                               input vinsn_vec_t h2, input vinsn_vec_t hd);
    int waited;
    waited = 0;
    drive_request(op, vs1, u1, vs2, u2, vd, ud);
    @(negedge clk_i);
    while (!req_ready_o && waited < 50) begin
      @(negedge clk_i);
      waited++;
    end
    if (!req_ready_o) begin
      errors++;
      $display("Timeout: sequencer never accepted the %s request", op.name());
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    @(negedge clk_i);
    check_bit(pe_req_valid_o, 1'b1, "pe_req_valid_o");
    check_vid(pe_req_id_o, id, "pe_req_id_o");
    check_op(pe_req_op_o, op, "pe_req_op_o");
    check_vreg(pe_req_vs1_o, vs1, "pe_req_vs1_o");
    check_vreg(pe_req_vs2_o, vs2, "pe_req_vs2_o");
    check_vreg(pe_req_vd_o, vd, "pe_req_vd_o");
    check_vec(pe_hazard_vs1_o, h1, "pe_hazard_vs1_o");
    check_vec(pe_hazard_vs2_o, h2, "pe_hazard_vs2_o");
    check_vec(pe_hazard_vd_o, hd, "pe_hazard_vd_o");
    check_bit(vinsn_running_o[id], 1'b1, "running bit of issued ID");
    // Table row is everything the new instruction waits on
    check_vec(hazard_table_o[id], h1 | h2 | hd, "hazard table row");
  endtask

  // Request must see req_ready_o low for the whole window
  task automatic stall_request(input seq_op_e op, input vreg_t vs1, input logic u1,
                               input vreg_t vs2, input logic u2, input vreg_t vd,
                               input logic ud, input int cycles);
    drive_request(op, vs1, u1, vs2, u2, vd, ud);
    for (int k = 0; k < cycles; k++) begin
      @(negedge clk_i);
      check_bit(req_ready_o, 1'b0, "req_ready_o during stall");
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic pulse_done(input vfu_e unit, input vid_t id);
    @(posedge clk_i);
    unit_done_i[unit][id] <= 1'b1;
    @(posedge clk_i);
    unit_done_i <= '0;
    @(negedge clk_i);
    check_bit(vinsn_running_o[id], 1'b0, "running bit after done");
    // No row may still wait on a finished ID
    for (int r = 0; r < `SEQ_NR_VINSN; r++) begin
      check_bit(hazard_table_o[r][id], 1'b0, "hazard table column after done");
    end
  endtask

  task automatic pulse_ack(input logic err, input logic exp_err);
    @(posedge clk_i);
    addrgen_ack_i   <= 1'b1;
    addrgen_error_i <= err;
    @(negedge clk_i);
    check_bit(resp_valid_o, 1'b1, "resp_valid_o at acknowledge");
    check_bit(resp_error_o, exp_err, "resp_error_o");
    @(posedge clk_i);
    addrgen_ack_i   <= 1'b0;
    addrgen_error_i <= 1'b0;
  endtask

  ////////////////////////////////
  // Main sequence
  ////////////////////////////////

  initial begin : main_seq
    int fd, n, op, vs1, u1, vs2, u2, vd, ud, id, h1, h2, hd, arg;
    string kind, rest;
    rst_ni          <= 1'b0;
    req_valid_i     <= 1'b0;
    req_op_i        <= VADD;
    req_vs1_i       <= '0;
    req_vs2_i       <= '0;
    req_vd_i        <= '0;
    req_use_vs1_i   <= 1'b0;
    req_use_vs2_i   <= 1'b0;
    req_use_vd_i    <= 1'b0;
    pe_req_ready_i  <= 1'b1;
    addrgen_ack_i   <= 1'b0;
    addrgen_error_i <= 1'b0;
    unit_done_i     <= '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    fd = $fopen("sim/seq_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the golden event file");
    end else begin
      while ($fscanf(fd, " %s", kind) == 1) begin
        n = 0;
        case (kind)
          "R": begin
            n = $fscanf(fd, "%d %d %d %d %d %d %d %d %h %h %h",
                        op, vs1, u1, vs2, u2, vd, ud, id, h1, h2, hd);
            issue_request(seq_op_e'(op), vreg_t'(vs1), u1 != 0, vreg_t'(vs2), u2 != 0,
                          vreg_t'(vd), ud != 0, vid_t'(id), vinsn_vec_t'(h1),
                          vinsn_vec_t'(h2), vinsn_vec_t'(hd));
            n = (n == 11) ? 1 : 0;
          end
          "S": begin
            n = $fscanf(fd, "%d %d %d %d %d %d %d %d", op, vs1, u1, vs2, u2, vd, ud, arg);
            stall_request(seq_op_e'(op), vreg_t'(vs1), u1 != 0, vreg_t'(vs2), u2 != 0,
                          vreg_t'(vd), ud != 0, arg);
            n = (n == 8) ? 1 : 0;
          end
          "D": begin
            n = $fscanf(fd, "%d %d", arg, id);
            pulse_done(vfu_e'(arg), vid_t'(id));
            n = (n == 2) ? 1 : 0;
          end
          "A": begin
            n = $fscanf(fd, "%d %d", arg, id);
            pulse_ack(arg != 0, id != 0);
            n = (n == 2) ? 1 : 0;
          end
          "I": begin
            n = $fscanf(fd, "%d", arg);
            @(negedge clk_i);
            check_bit(idle_o, arg != 0, "idle_o");
          end
          default: begin
            // Comment lines are skipped to their end
            n = (kind.substr(0, 0) == "#") ? 1 : 0;
            void'($fgets(rest, fd));
          end
        endcase
        if (n != 1) begin
          errors++;
          $display("Malformed line of kind %s in the golden event file", kind);
        end
      end
      $fclose(fd);
    end
    repeat (2) @(posedge clk_i);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: source/vec_sequencer.sv
//////////////////////////////
// Vector instruction sequencer
// Top level joining ID tracking,
// hazard scoreboard, unit queues
// and issue control
//////////////////////////////

`include "seq_macros.svh"

module vec_sequencer import seq_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Dispatcher
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  input  seq_op_e                         req_op_i,
  input  vreg_t                           req_vs1_i,
  input  logic                            req_use_vs1_i,
  input  vreg_t                           req_vs2_i,
  input  logic                            req_use_vs2_i,
  input  vreg_t                           req_vd_i,
  input  logic                            req_use_vd_i,
  output logic                            resp_valid_o,
  output logic                            resp_error_o,
  output logic                            idle_o,
  // Processing elements
  output logic                            pe_req_valid_o,
  input  logic                            pe_req_ready_i,
  output vid_t                            pe_req_id_o,
  output seq_op_e                         pe_req_op_o,
  output vreg_t                           pe_req_vs1_o,
  output vreg_t                           pe_req_vs2_o,
  output vreg_t                           pe_req_vd_o,
  output vinsn_vec_t                      pe_hazard_vs1_o,
  output vinsn_vec_t                      pe_hazard_vs2_o,
  output vinsn_vec_t                      pe_hazard_vd_o,
  output vinsn_vec_t                      vinsn_running_o,
  output vinsn_vec_t [`SEQ_NR_VINSN-1:0]  hazard_table_o,
  input  vinsn_vec_t [`SEQ_NR_UNITS-1:0]  unit_done_i,
  // Address generation
  input  logic                            addrgen_ack_i,
  input  logic                            addrgen_error_i
);

  logic       issue, id_full, unit_free;
  vid_t       issue_id, next_id;
  vfu_e       req_unit;
  vinsn_vec_t running_next;
  vinsn_vec_t hazard_vs1, hazard_vs2, hazard_vd;

  vinsn_tracker i_tracker (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .issue_i             (issue),
    .issue_id_i          (issue_id),
    .issue_unit_i        (req_unit),
    .unit_done_i         (unit_done_i),
    .next_id_o           (next_id),
    .full_o              (id_full),
    .vinsn_running_o     (vinsn_running_o),
    .vinsn_running_next_o(running_next),
    .idle_o              (idle_o)
  );

  vreg_scoreboard i_scoreboard (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .issue_i             (issue),
    .issue_id_i          (issue_id),
    .req_vs1_i           (req_vs1_i),
    .req_use_vs1_i       (req_use_vs1_i),
    .req_vs2_i           (req_vs2_i),
    .req_use_vs2_i       (req_use_vs2_i),
    .req_vd_i            (req_vd_i),
    .req_use_vd_i        (req_use_vd_i),
    .vinsn_running_next_i(running_next),
    .hazard_vs1_o        (hazard_vs1),
    .hazard_vs2_o        (hazard_vs2),
    .hazard_vd_o         (hazard_vd),
    .hazard_table_o      (hazard_table_o)
  );

  // The issued unit is the pending request's unit
  unit_queue_ctrl i_queue_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue_i     (issue),
    .issue_unit_i(req_unit),
    .req_unit_i  (req_unit),
    .unit_done_i (unit_done_i),
    .unit_free_o (unit_free)
  );

  issue_ctrl i_issue_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_vs1_i      (req_vs1_i),
    .req_vs2_i      (req_vs2_i),
    .req_vd_i       (req_vd_i),
    .req_use_vs1_i  (req_use_vs1_i),
    .req_use_vs2_i  (req_use_vs2_i),
    .req_use_vd_i   (req_use_vd_i),
    .id_full_i      (id_full),
    .unit_free_i    (unit_free),
    .next_id_i      (next_id),
    .hazard_vs1_i   (hazard_vs1),
    .hazard_vs2_i   (hazard_vs2),
    .hazard_vd_i    (hazard_vd),
    .pe_req_ready_i (pe_req_ready_i),
    .addrgen_ack_i  (addrgen_ack_i),
    .addrgen_error_i(addrgen_error_i),
    .req_ready_o    (req_ready_o),
    .req_unit_o     (req_unit),
    .issue_o        (issue),
    .issue_id_o     (issue_id),
    .pe_req_valid_o (pe_req_valid_o),
    .pe_req_id_o    (pe_req_id_o),
    .pe_req_op_o    (pe_req_op_o),
    .pe_req_vs1_o   (pe_req_vs1_o),
    .pe_req_vs2_o   (pe_req_vs2_o),
    .pe_req_vd_o    (pe_req_vd_o),
    .pe_hazard_vs1_o(pe_hazard_vs1_o),
    .pe_hazard_vs2_o(pe_hazard_vs2_o),
    .pe_hazard_vd_o (pe_hazard_vd_o),
    .resp_valid_o   (resp_valid_o),
    .resp_error_o   (resp_error_o)
  );

endmodule

// File: source/issue_ctrl.sv
//////////////////////////////
// Issue control
// Dispatcher handshake, request register
// toward the processing elements and
// the load/store acknowledge wait
//////////////////////////////

module issue_ctrl import seq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_valid_i,
  input  seq_op_e    req_op_i,
  input  vreg_t      req_vs1_i,
  input  vreg_t      req_vs2_i,
  input  vreg_t      req_vd_i,
  input  logic       req_use_vs1_i,
  input  logic       req_use_vs2_i,
  input  logic       req_use_vd_i,
  input  logic       id_full_i,
  input  logic       unit_free_i,
  input  vid_t       next_id_i,
  input  vinsn_vec_t hazard_vs1_i,
  input  vinsn_vec_t hazard_vs2_i,
  input  vinsn_vec_t hazard_vd_i,
  input  logic       pe_req_ready_i,
  input  logic       addrgen_ack_i,
  input  logic       addrgen_error_i,
  output logic       req_ready_o,
  output vfu_e       req_unit_o,
  output logic       issue_o,
  output vid_t       issue_id_o,
  output logic       pe_req_valid_o,
  output vid_t       pe_req_id_o,
  output seq_op_e    pe_req_op_o,
  output vreg_t      pe_req_vs1_o,
  output vreg_t      pe_req_vs2_o,
  output vreg_t      pe_req_vd_o,
  output vinsn_vec_t pe_hazard_vs1_o,
  output vinsn_vec_t pe_hazard_vs2_o,
  output vinsn_vec_t pe_hazard_vd_o,
  output logic       resp_valid_o,
  output logic       resp_error_o
);

  seq_state_e state_d, state_q;
  logic       pe_hold;

  assign req_unit_o = op_unit(req_op_i);

  // Previous request still waiting on the operand requesters
  assign pe_hold = pe_req_valid_o && !pe_req_ready_i;

  ////////////////////////////////
  // Acceptance
  ////////////////////////////////

  assign req_ready_o = (state_q == ST_IDLE) && !pe_hold && !id_full_i && unit_free_i;
  assign issue_o     = req_valid_i && req_ready_o;
  assign issue_id_o  = next_id_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        // Memory ops block the dispatcher until address generation answers
        if (issue_o && (req_unit_o == VFU_LOAD || req_unit_o == VFU_STORE)) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (addrgen_ack_i) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // One-cycle response at the acknowledge
  assign resp_valid_o = (state_q == ST_WAIT) && addrgen_ack_i;
  assign resp_error_o = resp_valid_o && addrgen_error_i;

  ////////////////////////////////
  // Request register
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= ST_IDLE;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q <= state_d;
      // Hold while stalled, drop once taken
      if (issue_o) pe_req_valid_o <= 1'b1;
      else if (pe_req_ready_i) pe_req_valid_o <= 1'b0;
    end
  end

  // Fields only load on acceptance
  always_ff @(posedge clk_i) begin
    if (issue_o) begin
      pe_req_id_o     <= next_id_i;
      pe_req_op_o     <= req_op_i;
      pe_req_vs1_o    <= req_vs1_i;
      pe_req_vs2_o    <= req_vs2_i;
      pe_req_vd_o     <= req_vd_i;
      pe_hazard_vs1_o <= hazard_vs1_i;
      pe_hazard_vs2_o <= hazard_vs2_i;
      pe_hazard_vd_o  <= hazard_vd_i;
    end
  end

  // Back-pressure freezes the whole request
  a_pe_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_o && !pe_req_ready_i |=> pe_req_valid_o && $stable(pe_req_id_o) &&
      $stable(pe_req_op_o) && $stable(pe_req_vs1_o) && $stable(pe_req_vs2_o) &&
      $stable(pe_req_vd_o) && $stable(pe_hazard_vs1_o) && $stable(pe_hazard_vs2_o) &&
      $stable(pe_hazard_vd_o)
  );

endmodule

// File: source/unit_queue_ctrl.sv
//////////////////////////////
// Unit queue control
// Counts instructions queued per unit
// and flags room for one more
//////////////////////////////

`include "seq_macros.svh"

module unit_queue_ctrl import seq_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            issue_i,
  input  vfu_e                            issue_unit_i,
  input  vfu_e                            req_unit_i,
  input  vinsn_vec_t [`SEQ_NR_UNITS-1:0]  unit_done_i,
  output logic                            unit_free_o
);

  // Depths in vfu_e order
  localparam logic [`SEQ_CNT_W-1:0] unit_depth [`SEQ_NR_UNITS] = '{
    `SEQ_CNT_W'(`SEQ_ALU_QDEPTH),
    `SEQ_CNT_W'(`SEQ_MFPU_QDEPTH),
    `SEQ_CNT_W'(`SEQ_VLDU_QDEPTH),
    `SEQ_CNT_W'(`SEQ_VSTU_QDEPTH)
  };

  logic [`SEQ_NR_UNITS-1:0][`SEQ_CNT_W-1:0] cnt_q;

  for (genvar u = 0; u < `SEQ_NR_UNITS; u++) begin : gen_unit_cnt
    logic cnt_up, cnt_down;

    // Up on issue to this unit, down on any completion there
    assign cnt_up   = issue_i && (issue_unit_i == vfu_e'(u));
    assign cnt_down = |unit_done_i[u];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[u] <= '0;
      end else if (cnt_up && !cnt_down) begin
        cnt_q[u] <= cnt_q[u] + 1'b1;
      end else if (cnt_down && !cnt_up) begin
        cnt_q[u] <= cnt_q[u] - 1'b1;
      end
      // Issue and done together leave the count unchanged
    end

    // Issue gating keeps each queue within its depth
    a_cnt_in_depth: assert property (
      @(posedge clk_i) disable iff (!rst_ni) cnt_q[u] <= unit_depth[u]
    );
  end

  // Room left in the unit the pending request targets
  assign unit_free_o = cnt_q[req_unit_i] < unit_depth[req_unit_i];

endmodule

// File: source/vreg_scoreboard.sv
//////////////////////////////
// Vector register scoreboard
// Read and write lists per register,
// RAW/WAR/WAW hazard vectors and the
// global hazard table
//////////////////////////////

`include "seq_macros.svh"

module vreg_scoreboard import seq_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            issue_i,
  input  vid_t                            issue_id_i,
  input  vreg_t                           req_vs1_i,
  input  logic                            req_use_vs1_i,
  input  vreg_t                           req_vs2_i,
  input  logic                            req_use_vs2_i,
  input  vreg_t                           req_vd_i,
  input  logic                            req_use_vd_i,
  input  vinsn_vec_t                      vinsn_running_next_i,
  output vinsn_vec_t                      hazard_vs1_o,
  output vinsn_vec_t                      hazard_vs2_o,
  output vinsn_vec_t                      hazard_vd_o,
  output vinsn_vec_t [`SEQ_NR_VINSN-1:0]  hazard_table_o
);

  ////////////////////////////////
  // Access lists
  ////////////////////////////////

  // Last reader and last writer of every register
  logic [`SEQ_NR_VREGS-1:0] rd_valid_d, rd_valid_q;
  logic [`SEQ_NR_VREGS-1:0] wr_valid_d, wr_valid_q;
  vid_t [`SEQ_NR_VREGS-1:0] rd_vid_d, rd_vid_q;
  vid_t [`SEQ_NR_VREGS-1:0] wr_vid_d, wr_vid_q;

  vinsn_vec_t raw_vs1, raw_vs2, war_vd, waw_vd;
  vinsn_vec_t [`SEQ_NR_VINSN-1:0] table_d;

  always_comb begin
    raw_vs1 = '0;
    raw_vs2 = '0;
    war_vd  = '0;
    waw_vd  = '0;
    // RAW on the sources
    if (req_use_vs1_i && wr_valid_q[req_vs1_i]) raw_vs1[wr_vid_q[req_vs1_i]] = 1'b1;
    if (req_use_vs2_i && wr_valid_q[req_vs2_i]) raw_vs2[wr_vid_q[req_vs2_i]] = 1'b1;
    // WAR and WAW on the destination
    if (req_use_vd_i && rd_valid_q[req_vd_i]) war_vd[rd_vid_q[req_vd_i]] = 1'b1;
    if (req_use_vd_i && wr_valid_q[req_vd_i]) waw_vd[wr_vid_q[req_vd_i]] = 1'b1;
  end

  // A reader of vd must finish before it gets overwritten
  assign hazard_vs1_o = (raw_vs1 | war_vd) & vinsn_running_next_i;
  assign hazard_vs2_o = (raw_vs2 | war_vd) & vinsn_running_next_i;
  assign hazard_vd_o  = waw_vd & vinsn_running_next_i;

  ////////////////////////////////
  // Update on issue and done
  ////////////////////////////////

  always_comb begin
    rd_valid_d = rd_valid_q;
    wr_valid_d = wr_valid_q;
    rd_vid_d   = rd_vid_q;
    wr_vid_d   = wr_vid_q;
    table_d    = hazard_table_o;
    if (issue_i) begin
      // New instruction becomes writer of vd and reader of its sources
      if (req_use_vd_i) begin
        wr_vid_d[req_vd_i]   = issue_id_i;
        wr_valid_d[req_vd_i] = 1'b1;
      end
      if (req_use_vs1_i) begin
        rd_vid_d[req_vs1_i]   = issue_id_i;
        rd_valid_d[req_vs1_i] = 1'b1;
      end
      if (req_use_vs2_i) begin
        rd_vid_d[req_vs2_i]   = issue_id_i;
        rd_valid_d[req_vs2_i] = 1'b1;
      end
      // Row holds every instruction the new one waits on
      table_d[issue_id_i] = hazard_vs1_o | hazard_vs2_o | hazard_vd_o;
    end
    // Drop entries of finished instructions
    for (int v = 0; v < `SEQ_NR_VREGS; v++) begin
      rd_valid_d[v] &= vinsn_running_next_i[rd_vid_d[v]];
      wr_valid_d[v] &= vinsn_running_next_i[wr_vid_d[v]];
    end
    // Clear columns of finished IDs, and rows that no longer run
    for (int i = 0; i < `SEQ_NR_VINSN; i++) begin
      table_d[i] &= vinsn_running_next_i;
      if (!vinsn_running_next_i[i]) table_d[i] = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q     <= '0;
      wr_valid_q     <= '0;
      hazard_table_o <= '0;
    end else begin
      rd_valid_q     <= rd_valid_d;
      wr_valid_q     <= wr_valid_d;
      hazard_table_o <= table_d;
    end
  end

  // Reader and writer IDs of the lists
  always_ff @(posedge clk_i) begin
    rd_vid_q <= rd_vid_d;
    wr_vid_q <= wr_vid_d;
  end

endmodule

// File: source/vinsn_tracker.sv
//////////////////////////////
// Instruction ID tracker
// Hands out the lowest free ID and
// keeps the running set per unit
//////////////////////////////

`include "seq_macros.svh"

module vinsn_tracker import seq_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            issue_i,
  input  vid_t                            issue_id_i,
  input  vfu_e                            issue_unit_i,
  input  vinsn_vec_t [`SEQ_NR_UNITS-1:0]  unit_done_i,
  output vid_t                            next_id_o,
  output logic                            full_o,
  output vinsn_vec_t                      vinsn_running_o,
  output vinsn_vec_t                      vinsn_running_next_o,
  output logic                            idle_o
);

  // Row per unit, column per instruction ID
  vinsn_vec_t [`SEQ_NR_UNITS-1:0] unit_running_d, unit_running_q;

  always_comb begin
    unit_running_d = unit_running_q;
    // Completed instructions leave their unit
    for (int u = 0; u < `SEQ_NR_UNITS; u++) begin
      unit_running_d[u] &= ~unit_done_i[u];
    end
    // New instruction starts on its target unit
    if (issue_i) begin
      unit_running_d[issue_unit_i][issue_id_i] = 1'b1;
    end
    // Overall set is the union of all units
    vinsn_running_next_o = '0;
    for (int u = 0; u < `SEQ_NR_UNITS; u++) begin
      vinsn_running_next_o |= unit_running_d[u];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unit_running_q  <= '0;
      vinsn_running_o <= '0;
    end else begin
      unit_running_q  <= unit_running_d;
      vinsn_running_o <= vinsn_running_next_o;
    end
  end

  // Leading-zero search from the LSB for the lowest free ID
  always_comb begin
    next_id_o = '0;
    for (int i = `SEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!vinsn_running_o[i]) next_id_o = vid_t'(i);
    end
  end

  assign full_o = &vinsn_running_o;
  // Idle once nothing runs anywhere
  assign idle_o = ~|vinsn_running_o;

  // Issue control must never accept with every ID taken
  a_no_issue_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_i |-> !full_o
  );

endmodule

// File: source/seq_pkg.sv
//////////////////////////////
// Vector sequencer types
// IDs, register indices, operations,
// units, issue states and the
// operation to unit mapping
//////////////////////////////

`include "seq_macros.svh"

package seq_pkg;

  // One instruction ID
  typedef logic [$clog2(`SEQ_NR_VINSN)-1:0] vid_t;
  // One bit per instruction ID
  typedef logic [`SEQ_NR_VINSN-1:0] vinsn_vec_t;
  // Vector register index
  typedef logic [$clog2(`SEQ_NR_VREGS)-1:0] vreg_t;

  // Decoded operations
  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VMUL,
    VMACC,
    VLE,
    VSE
  } seq_op_e;

  // Functional units, also the row index of the running matrix
  typedef enum logic [1:0] {
    VFU_ALU,
    VFU_MFPU,
    VFU_LOAD,
    VFU_STORE
  } vfu_e;

  // Issue FSM states
  typedef enum logic {
    ST_IDLE,
    ST_WAIT
  } seq_state_e;

  // Unit that executes an operation
  function automatic vfu_e op_unit(seq_op_e op);
    unique case (op)
      VADD, VSUB:  op_unit = VFU_ALU;
      VMUL, VMACC: op_unit = VFU_MFPU;
      VLE:         op_unit = VFU_LOAD;
      default:     op_unit = VFU_STORE;
    endcase
  endfunction

endpackage

// File: source/seq_macros.svh
//////////////////////////////
// Vector sequencer sizes
// Build-time counts and per-unit
// instruction queue depths
//////////////////////////////

`ifndef SEQ_MACROS_SVH
`define SEQ_MACROS_SVH

// Instruction IDs in flight at once
`define SEQ_NR_VINSN 8
// Architectural vector registers
`define SEQ_NR_VREGS 32
// ALU, MFPU, load and store
`define SEQ_NR_UNITS 4

// Queue depth of each unit
`define SEQ_ALU_QDEPTH  2
`define SEQ_MFPU_QDEPTH 2
`define SEQ_VLDU_QDEPTH 1
`define SEQ_VSTU_QDEPTH 1

// Wide enough to hold the largest depth
`define SEQ_CNT_W 2

`endif
